// File: filelist.f
design/periph_pkg.sv
design/periph_addr_decoder.sv
design/led_sb_ctrl.sv
design/sw_sb_ctrl.sv
design/periph_subsys_top.sv
verif/periph_subsys_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := periph_subsys_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Pass message found in $(LOG)"; \
	else \
	  echo "Pass message missing from $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/periph_subsys_tb.sv
`default_nettype none
`timescale 1ns/100ps

module periph_subsys_tb
  import periph_pkg::*;
();

  localparam int          CLK_PERIOD  = 40;
  localparam int          HALF        = 8;     // Blink half period in cycles.
  localparam int          POLL_LIMIT  = 10;    // Reads before a poll gives up.
  localparam int          WATCHDOG    = 5000;  // Cycles for the whole run.
  localparam logic [7:0]  NO_BASE     = 8'h07; // Unmapped upper byte.
  localparam logic [31:0] LED_MASK    = (32'd1 << W_LED) - 32'd1;
  localparam logic [31:0] SW_MASK     = (32'd1 << W_SW) - 32'd1;

  logic             clk;
  logic             rst;
  sb_req_t          bus_req;
  logic [31:0]      read_data;
  logic [W_SW-1:0]  sw;
  logic [W_LED-1:0] led;

  integer seed;
  int     err_count;
  int     errs_at_start;
  int     tests_run;
  int     tests_failed;
  string  test_name;

  periph_subsys_top #(
    .blink_half_period (HALF)
  ) u_periph_subsys_top (
    .clk_i       (clk),
    .rst_i       (rst),
    .bus_req_i   (bus_req),
    .read_data_o (read_data),
    .sw_i        (sw),
    .led_o       (led)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic start_test(input string name);
    test_name     = name;
    errs_at_start = err_count;
    tests_run++;
  endtask

  task automatic end_test();
    if (err_count == errs_at_start) begin
      $display("Test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d wrong check(s)", test_name, err_count - errs_at_start);
    end
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    err_count++;
    $display("FAIL %s: %s expected 0x%08h actual 0x%08h", test_name, what, exp, act);
  endtask

  task automatic report_error(input string msg);
    err_count++;
    $display("ERROR in %s: %s", test_name, msg);
  endtask

  // One write cycle, the register updates at the closing edge.
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    #2;
    bus_req.req   = 1'b1;
    bus_req.we    = 1'b1;
    bus_req.addr  = addr;
    bus_req.wdata = data;
    @(posedge clk);
    #2;
    bus_req.req = 1'b0;
    bus_req.we  = 1'b0;
  endtask

  // One read cycle, data sampled mid cycle after the request.
  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    #2;
    bus_req.req   = 1'b1;
    bus_req.we    = 1'b0;
    bus_req.addr  = addr;
    bus_req.wdata = 32'd0;
    @(posedge clk);
    #2;
    bus_req.req = 1'b0;
    @(negedge clk);
    data = read_data;
  endtask

  // Repeats a read until the expected word shows up.
  task automatic read_until(input logic [31:0] addr, input logic [31:0] exp,
                            output logic seen);
    logic [31:0] rd;
    int          tries;
    seen  = 1'b0;
    tries = 0;
    while (!seen && tries < POLL_LIMIT) begin
      bus_read(addr, rd);
      seen = (rd == exp);
      tries++;
    end
  endtask

  task automatic set_switches(input logic [W_SW-1:0] value);
    @(posedge clk);
    #2;
    sw = value;
  endtask

  task automatic test_reset_state();
    logic [31:0] rd;
    start_test("reset_state");
    @(negedge clk);
    if (led != '0) report_mismatch("led_o", 32'd0, 32'(led));
    if (read_data != 32'd0) report_mismatch("read_data_o", 32'd0, read_data);
    bus_read({LED_BASE, VALUE_OFFS}, rd);
    if (rd != 32'd0) report_mismatch("led value", 32'd0, rd);
    bus_read({LED_BASE, MODE_OFFS}, rd);
    if (rd != 32'(LED_STATIC)) report_mismatch("led mode", 32'(LED_STATIC), rd);
    bus_read({SW_BASE, MODE_OFFS}, rd);
    if (rd != 32'd0) report_mismatch("switch changed flag", 32'd0, rd);
    end_test();
  endtask

  task automatic test_led_static();
    logic [31:0] value;
    logic [31:0] exp;
    logic [31:0] rd;
    start_test("led_static");
    for (int i = 0; i < 4; i++) begin
      value = $random(seed);
      exp   = value & LED_MASK; // Only W_LED bits are stored.
      bus_write({LED_BASE, VALUE_OFFS}, value);
      @(negedge clk);
      if (32'(led) != exp) report_mismatch("led_o after write", exp, 32'(led));
      bus_read({LED_BASE, VALUE_OFFS}, rd);
      if (rd != exp) report_mismatch("led value readback", exp, rd);
    end
    end_test();
  endtask

  task automatic test_blink();
    logic [31:0]      value;
    logic [31:0]      rd;
    logic [W_LED-1:0] lit;
    logic [W_LED-1:0] samples [32];
    int               run_len;
    int               full_runs;
    int               tries;
    logic             first;
    start_test("blink");
    value = $random(seed) | 32'd1; // Lit value must differ from dark.
    lit   = value[W_LED-1:0];
    bus_write({LED_BASE, VALUE_OFFS}, value);
    bus_write({LED_BASE, MODE_OFFS}, 32'(LED_BLINK));
    bus_read({LED_BASE, MODE_OFFS}, rd);
    if (rd != 32'd1) report_mismatch("led mode readback", 32'd1, rd);
    for (int i = 0; i < 32; i++) begin
      @(negedge clk);
      samples[i] = led;
    end
    for (int i = 0; i < 32; i++) begin
      if (samples[i] != lit && samples[i] != '0) begin
        report_mismatch("led_o sample", 32'(lit), 32'(samples[i]));
      end
    end
    // First and last runs may be cut by the window.
    run_len   = 1;
    full_runs = 0;
    first     = 1'b1;
    for (int i = 1; i < 32; i++) begin
      if (samples[i] == samples[i-1]) begin
        run_len++;
      end else begin
        if (!first) begin
          full_runs++;
          if (run_len != HALF) report_mismatch("blink run length", 32'(HALF), 32'(run_len));
        end
        first   = 1'b0;
        run_len = 1;
      end
    end
    if (full_runs < 2) report_error("fewer than two complete blink runs in 32 cycles");
    // Back to static from the dark half, the value must show at once.
    tries = 0;
    while (led != '0 && tries < 2 * HALF) begin
      @(negedge clk);
      tries++;
    end
    bus_write({LED_BASE, MODE_OFFS}, 32'(LED_STATIC));
    @(negedge clk);
    if (led != lit) report_mismatch("led_o back in static mode", 32'(lit), 32'(led));
    end_test();
  endtask

  task automatic test_led_soft_reset();
    logic [31:0] rd;
    start_test("led_soft_reset");
    bus_write({LED_BASE, VALUE_OFFS}, $random(seed) | 32'd1);
    bus_write({LED_BASE, MODE_OFFS}, 32'(LED_BLINK));
    bus_write({LED_BASE, RESET_OFFS}, $random(seed));
    @(negedge clk);
    if (led != '0) report_mismatch("led_o after soft reset", 32'd0, 32'(led));
    bus_read({LED_BASE, VALUE_OFFS}, rd);
    if (rd != 32'd0) report_mismatch("led value", 32'd0, rd);
    bus_read({LED_BASE, MODE_OFFS}, rd);
    if (rd != 32'(LED_STATIC)) report_mismatch("led mode", 32'(LED_STATIC), rd);
    end_test();
  endtask

  task automatic test_switches();
    logic [31:0]     rnd;
    logic [W_SW-1:0] sw_val;
    logic [31:0]     rd;
    logic            seen;
    start_test("switches");
    rnd    = $random(seed);
    sw_val = rnd[W_SW-1:0];
    if (sw_val == sw) sw_val[0] = ~sw_val[0]; // Force an edge.
    set_switches(sw_val);
    read_until({SW_BASE, VALUE_OFFS}, 32'(sw_val) & SW_MASK, seen);
    if (!seen) report_error("synced switch value never appeared on readback");
    bus_read({SW_BASE, MODE_OFFS}, rd);
    if (rd != 32'd1) report_mismatch("changed flag after edge", 32'd1, rd);
    bus_write({SW_BASE, RESET_OFFS}, 32'd0);
    bus_read({SW_BASE, MODE_OFFS}, rd);
    if (rd != 32'd0) report_mismatch("changed flag after clear", 32'd0, rd);
    bus_read({SW_BASE, VALUE_OFFS}, rd);
    if (rd != (32'(sw_val) & SW_MASK)) begin
      report_mismatch("switch value after clear", 32'(sw_val) & SW_MASK, rd);
    end
    end_test();
  endtask

  task automatic test_decoding();
    logic [31:0] led_val;
    logic [31:0] rd;
    logic        seen;
    start_test("decoding");
    led_val = $random(seed) & LED_MASK;
    bus_write({LED_BASE, VALUE_OFFS}, led_val);
    set_switches(~sw);
    read_until({SW_BASE, MODE_OFFS}, 32'd1, seen);
    if (!seen) report_error("changed flag never set after a switch edge");
    // None of these may reach a peripheral.
    bus_write({NO_BASE, VALUE_OFFS}, ~led_val);
    bus_write({NO_BASE, MODE_OFFS}, 32'(LED_BLINK));
    bus_write({NO_BASE, RESET_OFFS}, 32'd0);
    bus_read({LED_BASE, VALUE_OFFS}, rd);
    if (rd != led_val) report_mismatch("led value", led_val, rd);
    bus_read({LED_BASE, MODE_OFFS}, rd);
    if (rd != 32'(LED_STATIC)) report_mismatch("led mode", 32'(LED_STATIC), rd);
    bus_read({SW_BASE, MODE_OFFS}, rd);
    if (rd != 32'd1) report_mismatch("changed flag", 32'd1, rd);
    bus_read({NO_BASE, VALUE_OFFS}, rd);
    if (rd != 32'd0) report_mismatch("unmapped read", 32'd0, rd);
    bus_read({8'hff, MODE_OFFS}, rd);
    if (rd != 32'd0) report_mismatch("unmapped read at 0xff", 32'd0, rd);
    @(negedge clk);
    if (32'(led) != led_val) report_mismatch("led_o", led_val, 32'(led));
    end_test();
  endtask

  // Hard limit on the whole run.
  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed         = 32'h5248_c6a4;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    clk          = 1'b0;
    rst          = 1'b1;
    bus_req      = '0;
    sw           = '0;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;

    test_reset_state();
    test_led_static();
    test_blink();
    test_led_soft_reset();
    test_switches();
    test_decoding();

    $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/periph_subsys_top.sv
`default_nettype none
`timescale 1ns/100ps

module periph_subsys_top
  import periph_pkg::*;
#(
  parameter int blink_half_period = 10_000_000
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  sb_req_t          bus_req_i,
  output logic [31:0]      read_data_o,
  input  logic [W_SW-1:0]  sw_i,   // Asynchronous board switches.
  output logic [W_LED-1:0] led_o
);

  sb_req_t     sw_req;
  sb_req_t     led_req;
  logic [31:0] sw_rdata;
  logic [31:0] led_rdata;

  // Routes requests and muxes read data back.
  periph_addr_decoder u_periph_addr_decoder (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_req_i   (bus_req_i),
    .sw_req_o    (sw_req),
    .led_req_o   (led_req),
    .sw_rdata_i  (sw_rdata),
    .led_rdata_i (led_rdata),
    .read_data_o (read_data_o)
  );

  led_sb_ctrl #(
    .blink_half_period (blink_half_period)
  ) u_led_sb_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_req_i   (led_req),
    .read_data_o (led_rdata),
    .led_o       (led_o)
  );

  sw_sb_ctrl u_sw_sb_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_req_i   (sw_req),
    .read_data_o (sw_rdata),
    .sw_i        (sw_i)
  );

endmodule

`default_nettype wire

// File: design/sw_sb_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module sw_sb_ctrl
  import periph_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  sb_req_t         bus_req_i,
  output logic [31:0]     read_data_o,
  input  logic [W_SW-1:0] sw_i
);

  logic            wr_en;
  logic            rd_en;
  logic            clr_flag;
  logic [23:0]     offs;
  logic [W_SW-1:0] sync1_q;   // Metastability stage.
  logic [W_SW-1:0] sync2_q;   // Safe to use.
  logic [W_SW-1:0] prev_q;    // Last synced sample.
  logic            sw_diff;
  logic            changed_q;

  assign offs     = bus_req_i.addr[23:0];
  assign wr_en    = bus_req_i.req & bus_req_i.we;
  assign rd_en    = bus_req_i.req & ~bus_req_i.we;
  assign clr_flag = wr_en & (offs == RESET_OFFS);

  // Two-flop synchronizer plus history stage.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= sw_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign sw_diff = (sync2_q != prev_q);

  // Sticky flag. Clear beats a simultaneous edge.
  always_ff @(posedge clk_i) begin
    if (rst_i || clr_flag) begin
      changed_q <= 1'b0;
    end else if (sw_diff) begin
      changed_q <= 1'b1;
    end
  end

  // Registered readback.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      read_data_o <= 32'd0;
    end else if (rd_en) begin
      case (offs)
        VALUE_OFFS: read_data_o <= 32'(sync2_q);
        MODE_OFFS:  read_data_o <= {31'd0, changed_q};
        default: ;
      endcase
    end
  end

  // The flag only rises after a synced change.
  a_flag_cause: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $rose(changed_q) |-> $past(sw_diff)
  ) else $error("sw: changed flag set without a switch edge");

endmodule

`default_nettype wire

// File: design/led_sb_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module led_sb_ctrl
  import periph_pkg::*;
#(
  parameter int blink_half_period = 10_000_000
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  sb_req_t          bus_req_i,
  output logic [31:0]      read_data_o,
  output logic [W_LED-1:0] led_o
);

  logic             wr_en;
  logic             rd_en;
  logic             soft_rst;
  logic             static_wr; // Mode write that selects static.
  logic [23:0]      offs;
  logic [W_LED-1:0] value_q;
  led_mode_e        mode_q;
  logic [31:0]      cnt_q;  // Blink phase counter.
  logic             cnt_wrap;
  logic             blank;  // Second half of the blink period.

  assign offs      = bus_req_i.addr[23:0];
  assign wr_en     = bus_req_i.req & bus_req_i.we;
  assign rd_en     = bus_req_i.req & ~bus_req_i.we;
  assign soft_rst  = wr_en & (offs == RESET_OFFS);
  assign static_wr = wr_en & (offs == MODE_OFFS) & ~bus_req_i.wdata[0];

  // Value and mode registers.
  always_ff @(posedge clk_i) begin
    if (rst_i || soft_rst) begin
      value_q <= '0;
      mode_q  <= LED_STATIC;
    end else if (wr_en) begin
      case (offs)
        VALUE_OFFS: value_q <= bus_req_i.wdata[W_LED-1:0];
        MODE_OFFS:  mode_q  <= led_mode_e'(bus_req_i.wdata[0]);
        default: ;
      endcase
    end
  end

  // Full period is two half periods.
  assign cnt_wrap = (cnt_q == 32'(2 * blink_half_period - 1));

  // Held at zero while static, so blinking always starts
  // with the lit half. Cleared together with a switch to static.
  always_ff @(posedge clk_i) begin
    if (rst_i || soft_rst || static_wr || mode_q == LED_STATIC) begin
      cnt_q <= 32'd0;
    end else if (cnt_wrap) begin
      cnt_q <= 32'd0;
    end else begin
      cnt_q <= cnt_q + 32'd1;
    end
  end

  assign blank = (cnt_q >= 32'(blink_half_period));
  assign led_o = blank ? '0 : value_q;

  // Registered readback, unknown offsets keep the last data.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      read_data_o <= 32'd0;
    end else if (rd_en) begin
      case (offs)
        VALUE_OFFS: read_data_o <= 32'(value_q);
        MODE_OFFS:  read_data_o <= {31'd0, mode_q};
        default: ;
      endcase
    end
  end

  // Static mode never blanks.
  a_static_shows_value: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (mode_q == LED_STATIC) |-> (led_o == value_q)
  ) else $error("led: static output differs from value");

endmodule

`default_nettype wire

// File: design/periph_addr_decoder.sv
`default_nettype none
`timescale 1ns/100ps

module periph_addr_decoder
  import periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  sb_req_t     bus_req_i,
  output sb_req_t     sw_req_o,
  output sb_req_t     led_req_o,
  input  logic [31:0] sw_rdata_i,
  input  logic [31:0] led_rdata_i,
  output logic [31:0] read_data_o
);

  periph_sel_e sel;
  periph_sel_e rd_sel_q; // Target of the last read.
  logic        rd_en;

  assign rd_en = bus_req_i.req & ~bus_req_i.we;

  // Upper address byte picks the peripheral.
  always_comb begin
    case (bus_req_i.addr[31:24])
      SW_BASE:  sel = SEL_SW;
      LED_BASE: sel = SEL_LED;
      default:  sel = SEL_NONE;
    endcase
  end

  // Same request to both, only the req bit is steered.
  always_comb begin
    sw_req_o      = bus_req_i;
    sw_req_o.req  = bus_req_i.req & (sel == SEL_SW);
    led_req_o     = bus_req_i;
    led_req_o.req = bus_req_i.req & (sel == SEL_LED);
  end

  // Peripherals register their read data, so the select
  // has to lag the request by one cycle as well.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_sel_q <= SEL_NONE;
    end else if (rd_en) begin
      rd_sel_q <= sel;
    end
  end

  always_comb begin
    case (rd_sel_q)
      SEL_SW:  read_data_o = sw_rdata_i;
      SEL_LED: read_data_o = led_rdata_i;
      default: read_data_o = 32'd0; // Unmapped read.
    endcase
  end

  // At most one peripheral sees a request.
  a_onehot_req: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(sw_req_o.req && led_req_o.req)
  ) else $error("decoder: both peripherals selected");

endmodule

`default_nettype wire

// File: design/periph_pkg.sv
`default_nettype none

package periph_pkg;

  // Board widths.
  localparam int W_LED = 16;
  localparam int W_SW  = 16;

  // Upper address byte of each peripheral.
  localparam logic [7:0] SW_BASE  = 8'h01;
  localparam logic [7:0] LED_BASE = 8'h02;

  // Register offsets inside a peripheral window.
  localparam logic [23:0] VALUE_OFFS = 24'h00;
  localparam logic [23:0] MODE_OFFS  = 24'h04; // Changed flag on the switch side.
  localparam logic [23:0] RESET_OFFS = 24'h24; // Write-only soft reset.

  // One system bus request, accepted in the cycle it is presented.
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } sb_req_t;

  // LED output mode.
  typedef enum logic {
    LED_STATIC = 1'b0,
    LED_BLINK  = 1'b1
  } led_mode_e;

  // Decoder target.
  typedef enum logic [1:0] {
    SEL_NONE = 2'd0, // Unmapped, reads return zero.
    SEL_SW   = 2'd1,
    SEL_LED  = 2'd2
  } periph_sel_e;

endpackage

`default_nettype wire
